//--- jvm_config.svh
`ifndef JVM_CONFIG_SVH
`define JVM_CONFIG_SVH

// datapath word, matches the JVM int
`define WORD_W 32

// decoded ops that may wait between decoder and executor
`define QUEUE_DEPTH 4

// operand stack entries
`define STACK_DEPTH 16

// local variable array entries, index taken from the low bits of arg1
`define LVA_DEPTH 16

`endif

//--- jvm_pkg.sv
`include "jvm_config.svh"

package jvm_pkg;

    // kept opcodes, standard JVM byte values
    typedef enum logic [7:0] {
        op_nop       = 8'h00,
        op_iconst_m1 = 8'h02, op_iconst_0 = 8'h03, op_iconst_1 = 8'h04,
        op_iconst_2  = 8'h05, op_iconst_3 = 8'h06, op_iconst_4 = 8'h07,
        op_iconst_5  = 8'h08,
        op_bipush    = 8'h10, op_sipush   = 8'h11,
        op_iload     = 8'h15,
        op_iload_0   = 8'h1a, op_iload_1  = 8'h1b, op_iload_2  = 8'h1c, op_iload_3  = 8'h1d,
        op_istore    = 8'h36,
        op_istore_0  = 8'h3b, op_istore_1 = 8'h3c, op_istore_2 = 8'h3d, op_istore_3 = 8'h3e,
        op_pop       = 8'h57,
        op_iadd      = 8'h60, op_isub     = 8'h64,
        op_iand      = 8'h7e, op_ior      = 8'h80, op_ixor     = 8'h82,
        op_ifeq      = 8'h99, op_ifne     = 8'h9a, op_iflt     = 8'h9b,
        op_ifge      = 8'h9c, op_ifgt     = 8'h9d, op_ifle     = 8'h9e,
        op_if_icmpeq = 8'h9f, op_if_icmpne = 8'ha0, op_if_icmplt = 8'ha1,
        op_if_icmpge = 8'ha2, op_if_icmpgt = 8'ha3, op_if_icmple = 8'ha4,
        op_goto      = 8'ha7
    } opcode_e;

    typedef struct packed {
        logic [7:0] arg1;
        logic [7:0] arg2;
    } arg_bytes_t;

    // same two bytes, literal/index view or branch offset view
    typedef union packed {
        arg_bytes_t         bytes;
        logic signed [15:0] offset;
    } instr_args_u;

    typedef struct packed {
        opcode_e     opcode;
        instr_args_u args;
    } instr_t;

    typedef enum logic [3:0] {
        push_const, push_arg, lva_read, lva_write, alu, cmp, goto_op, pop_op, nop_op
    } op_class_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor
    } alu_op_e;

    // bit 3 set for the two-operand form, low bits pick the relation
    typedef enum logic [3:0] {
        cmp_eq  = 4'h0, cmp_ne  = 4'h1, cmp_lt  = 4'h2,
        cmp_ge  = 4'h3, cmp_gt  = 4'h4, cmp_le  = 4'h5,
        icmp_eq = 4'h8, icmp_ne = 4'h9, icmp_lt = 4'ha,
        icmp_ge = 4'hb, icmp_gt = 4'hc, icmp_le = 4'hd
    } cmp_e;

    typedef struct packed {
        op_class_e                      op_class;
        alu_op_e                        alu_op;
        cmp_e                           cmp;
        logic [`WORD_W-1:0]             imm;        // sign-extended push value
        logic [$clog2(`LVA_DEPTH)-1:0]  lva_index;
        logic [1:0]                     argc;       // argument bytes after the opcode
        instr_args_u                    args;
        logic                           illegal;
    } dec_op_t;

    typedef struct packed {
        logic [15:0]        pc_offset;
        logic               jump;
        logic               pushed;
        logic [`WORD_W-1:0] push_value;
        logic               illegal;
        logic               stack_error;
    } retire_t;

endpackage

//--- eval_stack.sv
`timescale 1ns/10ps
`include "jvm_config.svh"

module eval_stack (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               push,
    input  logic                               pop,
    input  logic [`WORD_W-1:0]                 wdata,
    output logic [`WORD_W-1:0]                 top,
    output logic [$clog2(`STACK_DEPTH + 1)-1:0] depth
);

    localparam int PTR_W   = $clog2(`STACK_DEPTH);
    localparam int DEPTH_W = $clog2(`STACK_DEPTH + 1);

    logic [`WORD_W-1:0] mem [`STACK_DEPTH];
    logic [DEPTH_W-1:0] below;      // slot under the current top
    logic               do_push;
    logic               do_pop;

    assign do_push = push && depth != DEPTH_W'(`STACK_DEPTH);
    assign do_pop  = pop && depth != '0;
    assign below   = depth - DEPTH_W'(2);

    always_ff @(posedge clk) begin
        if (rst) begin
            depth <= '0;
        end else if (do_push) begin
            depth <= depth + 1'b1;
        end else if (do_pop) begin
            depth <= depth - 1'b1;
        end
    end

    // top mirrors mem[depth-1] so a pop reads it without a memory lookup
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[depth[PTR_W-1:0]] <= wdata;
            top                   <= wdata;
        end else if (do_pop) begin
            top <= (depth > DEPTH_W'(1)) ? mem[below[PTR_W-1:0]] : '0;
        end
    end

    a_push_pop_excl: assert property (@(posedge clk) disable iff (rst) !(push && pop))
        else $error("eval_stack push and pop in the same cycle");

endmodule

//--- bc_alu.sv
`timescale 1ns/10ps
`include "jvm_config.svh"

module bc_alu import jvm_pkg::*; (
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    input  alu_op_e            alu_op,
    input  cmp_e               cmp,
    output logic [`WORD_W-1:0] result,
    output logic               taken
);

    logic [`WORD_W-1:0] rhs;
    logic               eq;
    logic               lt;

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;        // deeper operand minus top
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            default: result = '0;
        endcase
    end

    // ifxx forms compare against zero
    assign rhs = cmp[3] ? b : '0;
    assign eq  = a == rhs;
    assign lt  = $signed(a) < $signed(rhs);

    always_comb begin
        case (cmp_e'({1'b0, cmp[2:0]}))
            cmp_eq:  taken = eq;
            cmp_ne:  taken = !eq;
            cmp_lt:  taken = lt;
            cmp_ge:  taken = !lt;
            cmp_gt:  taken = !lt && !eq;
            cmp_le:  taken = lt || eq;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- bc_decoder.sv
`timescale 1ns/10ps
`include "jvm_config.svh"

module bc_decoder import jvm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_t  instr,
    output logic    push_valid,
    output dec_op_t op
);

    localparam int IDX_W = $clog2(`LVA_DEPTH);

    dec_op_t d;

    always_comb begin
        d = '0;
        d.op_class  = nop_op;
        d.alu_op    = alu_add;
        d.cmp       = cmp_eq;
        d.args      = instr.args;
        d.lva_index = instr.args.bytes.arg1[IDX_W-1:0];    // long forms index by arg1
        case (instr.opcode)
            op_iconst_m1, op_iconst_0, op_iconst_1, op_iconst_2,
            op_iconst_3, op_iconst_4, op_iconst_5: begin
                d.op_class = push_const;
                d.imm      = `WORD_W'($signed(8'(instr.opcode - 8'h03)));  // m1 lands on -1
            end
            op_bipush: begin
                d.op_class = push_arg;
                d.argc     = 2'd1;
                d.imm      = `WORD_W'($signed(instr.args.bytes.arg1));
            end
            op_sipush: begin
                d.op_class = push_arg;
                d.argc     = 2'd2;
                d.imm      = `WORD_W'($signed({instr.args.bytes.arg1, instr.args.bytes.arg2}));
            end
            op_iload: begin
                d.op_class = lva_read;
                d.argc     = 2'd1;
            end
            op_iload_0, op_iload_1, op_iload_2, op_iload_3: begin
                d.op_class  = lva_read;
                d.lva_index = IDX_W'(instr.opcode - op_iload_0);
            end
            op_istore: begin
                d.op_class = lva_write;
                d.argc     = 2'd1;
            end
            op_istore_0, op_istore_1, op_istore_2, op_istore_3: begin
                d.op_class  = lva_write;
                d.lva_index = IDX_W'(instr.opcode - op_istore_0);
            end
            op_iadd: begin
                d.op_class = alu;
                d.alu_op   = alu_add;
            end
            op_isub: begin
                d.op_class = alu;
                d.alu_op   = alu_sub;
            end
            op_iand: begin
                d.op_class = alu;
                d.alu_op   = alu_and;
            end
            op_ior: begin
                d.op_class = alu;
                d.alu_op   = alu_or;
            end
            op_ixor: begin
                d.op_class = alu;
                d.alu_op   = alu_xor;
            end
            op_pop:  d.op_class = pop_op;
            op_ifeq, op_ifne, op_iflt, op_ifge, op_ifgt, op_ifle: begin
                d.op_class = cmp;
                d.argc     = 2'd2;
                d.cmp      = cmp_e'({1'b0, 3'(instr.opcode - op_ifeq)});
            end
            op_if_icmpeq, op_if_icmpne, op_if_icmplt,
            op_if_icmpge, op_if_icmpgt, op_if_icmple: begin
                d.op_class = cmp;
                d.argc     = 2'd2;
                d.cmp      = cmp_e'({1'b1, 3'(instr.opcode - op_if_icmpeq)});
            end
            op_goto: begin
                d.op_class = goto_op;
                d.argc     = 2'd2;
            end
            op_nop:  d.op_class = nop_op;
            default: d.illegal  = 1'b1;             // also invoke and return
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            op <= d;
        end
    end

endmodule

//--- instr_queue.sv
`timescale 1ns/10ps
`include "jvm_config.svh"

module instr_queue import jvm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wr,
    input  dec_op_t wdata,
    input  logic    rd,
    output logic    head_valid,
    output dec_op_t head
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    dec_op_t          mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;

    assign full       = count == (PTR_W + 1)'(`QUEUE_DEPTH);
    assign head_valid = count != '0;
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // caller keeps at most QUEUE_DEPTH instructions in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full)
        else $error("instr_queue written while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd |-> head_valid)
        else $error("instr_queue read while empty");

endmodule

//--- bc_execute.sv
`timescale 1ns/10ps
`include "jvm_config.svh"

module bc_execute import jvm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    head_valid,
    input  dec_op_t head,
    output logic    pop,
    output logic    retire_valid,
    output retire_t retire
);

    localparam int DEPTH_W = $clog2(`STACK_DEPTH + 1);

    typedef enum logic [2:0] {
        s_idle, s_pop_b, s_pop_a, s_exec, s_push, s_retire
    } state_e;

    state_e             state;
    dec_op_t            op;             // op being executed
    logic [`WORD_W-1:0] a;              // deeper operand, or the only one
    logic [`WORD_W-1:0] b;              // top of stack for two-operand ops
    logic [`WORD_W-1:0] value;          // result waiting to be pushed
    logic               jump;
    logic               pushed;
    logic               stack_error;
    logic [`WORD_W-1:0] lva [`LVA_DEPTH];
    logic               stk_push;
    logic               stk_pop;
    logic               stk_empty;
    logic               stk_full;
    logic [`WORD_W-1:0] stk_top;
    logic [DEPTH_W-1:0] stk_depth;
    logic [`WORD_W-1:0] alu_result;
    logic               taken;

    eval_stack eval_stack_inst (
        .clk   (clk),
        .rst   (rst),
        .push  (stk_push),
        .pop   (stk_pop),
        .wdata (value),
        .top   (stk_top),
        .depth (stk_depth)
    );

    bc_alu bc_alu_inst (
        .a      (a),
        .b      (b),
        .alu_op (op.alu_op),
        .cmp    (op.cmp),
        .result (alu_result),
        .taken  (taken)
    );

    assign pop       = state == s_idle && head_valid;
    assign stk_empty = stk_depth == '0;
    assign stk_full  = stk_depth == DEPTH_W'(`STACK_DEPTH);
    assign stk_pop   = (state == s_pop_b || state == s_pop_a) && !stk_empty;
    assign stk_push  = state == s_push && !stk_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= s_idle;
            jump        <= 1'b0;
            pushed      <= 1'b0;
            stack_error <= 1'b0;
        end else begin
            case (state)
                s_idle: if (head_valid) begin
                    jump        <= head.op_class == goto_op;
                    pushed      <= 1'b0;
                    stack_error <= 1'b0;
                    case (head.op_class)
                        push_const, push_arg, lva_read: state <= s_push;
                        alu:                state <= s_pop_b;
                        cmp:                state <= head.cmp[3] ? s_pop_b : s_pop_a;
                        lva_write, pop_op:  state <= s_pop_a;
                        default:            state <= s_retire;     // goto, nop, illegal
                    endcase
                end
                s_pop_b: begin
                    if (stk_empty) stack_error <= 1'b1;
                    state <= s_pop_a;
                end
                s_pop_a: begin
                    if (stk_empty) stack_error <= 1'b1;
                    state <= s_exec;
                end
                s_exec: begin
                    if (op.op_class == cmp) jump <= taken;
                    state <= (op.op_class == alu) ? s_push : s_retire;
                end
                s_push: begin
                    if (stk_full) stack_error <= 1'b1;
                    else pushed <= 1'b1;
                    state <= s_retire;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op    <= head;
            value <= (head.op_class == lva_read) ? lva[head.lva_index] : head.imm;
        end
        if (state == s_pop_b) b <= stk_empty ? '0 : stk_top;
        if (state == s_pop_a) a <= stk_empty ? '0 : stk_top;
        if (state == s_exec && op.op_class == alu) value <= alu_result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LVA_DEPTH; i++) begin
                lva[i] <= '0;
            end
        end else if (state == s_exec && op.op_class == lva_write) begin
            lva[op.lva_index] <= a;
        end
    end

    assign retire_valid = state == s_retire;

    always_comb begin
        if (op.illegal) begin
            retire.pc_offset = 16'd1;
        end else if (jump) begin
            retire.pc_offset = op.args.offset;
        end else begin
            retire.pc_offset = 16'(op.argc) + 16'd1;
        end
        retire.jump        = jump;
        retire.pushed      = pushed;
        retire.push_value  = pushed ? value : '0;
        retire.illegal     = op.illegal;
        retire.stack_error = stack_error;
    end

endmodule

//--- jvm_core.sv
`timescale 1ns/10ps

module jvm_core import jvm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_t  instr,
    output logic    retire_valid,
    output retire_t retire
);

    logic    dec_valid;
    dec_op_t dec_op;
    logic    head_valid;
    dec_op_t head;
    logic    head_pop;

    bc_decoder bc_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .push_valid  (dec_valid),
        .op          (dec_op)
    );

    // absorbs the variable executor latency
    instr_queue instr_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .wr         (dec_valid),
        .wdata      (dec_op),
        .rd         (head_pop),
        .head_valid (head_valid),
        .head       (head)
    );

    bc_execute bc_execute_inst (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head         (head),
        .pop          (head_pop),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

//--- tb_jvm_table.svh
`ifndef TB_JVM_TABLE_SVH
`define TB_JVM_TABLE_SVH

// rows run top to bottom against one shared stack and LVA
// opcode, arg1, arg2, chain, pc_offset, jump, pushed, push_value, illegal, stack_error
// chain set means the next row is strobed on the very next cycle

localparam int NUM_ROWS = 35;

localparam row_t ROWS [NUM_ROWS] = '{
    '{8'h08, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0005, 1'b0, 1'b0}, // iconst_5
    '{8'h10, 8'hf0, 8'h00, 1'b0, 16'h0002, 1'b0, 1'b1, 32'hffff_fff0, 1'b0, 1'b0}, // bipush -16
    '{8'h11, 8'h80, 8'h01, 1'b0, 16'h0003, 1'b0, 1'b1, 32'hffff_8001, 1'b0, 1'b0}, // sipush
    '{8'h3d, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // istore_2
    '{8'h15, 8'h02, 8'h00, 1'b0, 16'h0002, 1'b0, 1'b1, 32'hffff_8001, 1'b0, 1'b0}, // iload 2
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // pop
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0},
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // now empty
    // alu group, each result stays on the stack for the next op
    '{8'h10, 8'h0c, 8'h00, 1'b0, 16'h0002, 1'b0, 1'b1, 32'h0000_000c, 1'b0, 1'b0}, // bipush 12
    '{8'h08, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0005, 1'b0, 1'b0}, // iconst_5
    '{8'h60, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0011, 1'b0, 1'b0}, // iadd 12+5
    '{8'h06, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0003, 1'b0, 1'b0}, // iconst_3
    '{8'h64, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_000e, 1'b0, 1'b0}, // isub 17-3
    '{8'h10, 8'h0a, 8'h00, 1'b0, 16'h0002, 1'b0, 1'b1, 32'h0000_000a, 1'b0, 1'b0}, // bipush 10
    '{8'h7e, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_000a, 1'b0, 1'b0}, // iand
    '{8'h10, 8'h05, 8'h00, 1'b0, 16'h0002, 1'b0, 1'b1, 32'h0000_0005, 1'b0, 1'b0}, // bipush 5
    '{8'h80, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_000f, 1'b0, 1'b0}, // ior
    '{8'h02, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'hffff_ffff, 1'b0, 1'b0}, // iconst_m1
    '{8'h82, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'hffff_fff0, 1'b0, 1'b0}, // ixor
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // pop
    // branches
    '{8'h03, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0000, 1'b0, 1'b0}, // iconst_0
    '{8'h99, 8'h00, 8'h08, 1'b0, 16'h0008, 1'b1, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // ifeq taken
    '{8'h02, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'hffff_ffff, 1'b0, 1'b0},
    '{8'h05, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0002, 1'b0, 1'b0},
    '{8'ha1, 8'h00, 8'h10, 1'b0, 16'h0010, 1'b1, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // -1 < 2
    '{8'h04, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b1, 32'h0000_0001, 1'b0, 1'b0},
    '{8'h99, 8'h00, 8'h20, 1'b0, 16'h0003, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // not taken
    '{8'ha7, 8'hff, 8'hf0, 1'b0, 16'hfff0, 1'b1, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // goto back
    // error paths
    '{8'hb6, 8'h00, 8'h01, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b1, 1'b0}, // invoke
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b1}, // empty pop
    '{8'h00, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}, // nop
    // back to back burst of four
    '{8'h05, 8'h00, 8'h00, 1'b1, 16'h0001, 1'b0, 1'b1, 32'h0000_0002, 1'b0, 1'b0},
    '{8'h07, 8'h00, 8'h00, 1'b1, 16'h0001, 1'b0, 1'b1, 32'h0000_0004, 1'b0, 1'b0},
    '{8'h60, 8'h00, 8'h00, 1'b1, 16'h0001, 1'b0, 1'b1, 32'h0000_0006, 1'b0, 1'b0},
    '{8'h57, 8'h00, 8'h00, 1'b0, 16'h0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0, 1'b0}
};

`endif

//--- tb_jvm_core.sv
`timescale 1ns/10ps

module tb_jvm_core import jvm_pkg::*; ();

    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  arg1;
        logic [7:0]  arg2;
        logic        chain;         // strobe the next row without waiting
        logic [15:0] pc_offset;
        logic        jump;
        logic        pushed;
        logic [31:0] push_value;
        logic        illegal;
        logic        stack_error;
    } row_t;

`include "tb_jvm_table.svh"

    logic    clk = 1'b0;
    logic    rst;
    logic    instr_valid;
    instr_t  instr;
    logic    retire_valid;
    retire_t retire;

    int   issued  = 0;
    int   retired = 0;
    int   passes  = 0;
    int   fails   = 0;
    int   errors  = 0;          // retires that match no row
    logic row_bad;

    jvm_core jvm_core_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_field(input int row, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: row %0d %s is %h, expected %h", $time, row, name, got, exp);
            row_bad = 1'b1;
        end
    endtask

    task automatic check_retire(input int idx);
        row_t r;
        r       = ROWS[idx];
        row_bad = 1'b0;
        compare_field(idx, "pc_offset", 32'(retire.pc_offset), 32'(r.pc_offset));
        compare_field(idx, "jump", 32'(retire.jump), 32'(r.jump));
        compare_field(idx, "pushed", 32'(retire.pushed), 32'(r.pushed));
        compare_field(idx, "push_value", retire.push_value, r.push_value);
        compare_field(idx, "illegal", 32'(retire.illegal), 32'(r.illegal));
        compare_field(idx, "stack_error", 32'(retire.stack_error), 32'(r.stack_error));
        if (row_bad) begin
            fails++;
            $display("row %0d opcode %h: fail", idx, r.opcode);
        end else begin
            passes++;
            $display("row %0d opcode %h: ok", idx, r.opcode);
        end
    endtask

    // retire is sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (retired >= issued) begin
                $display("retire at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                check_retire(retired);
                retired++;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= {ROWS[i].opcode, ROWS[i].arg1, ROWS[i].arg2};
            issued++;
            if (!ROWS[i].chain) begin
                @(posedge clk);
                instr_valid <= 1'b0;
                wait (retired == issued);   // also drains a burst
            end
        end
        repeat (4) @(posedge clk);
        $display("rows %0d, passed %0d, failed %0d, stray retires %0d",
                 NUM_ROWS, passes, fails, errors);
        if (fails == 0 && errors == 0 && retired == NUM_ROWS) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // 50 cycles per row is far beyond the slowest op
    initial begin
        #(NUM_ROWS * 50 * CLK_PERIOD);
        $display("watchdog expired, only %0d of %0d instructions retired", retired, NUM_ROWS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
jvm_pkg.sv
eval_stack.sv
bc_alu.sv
bc_decoder.sv
instr_queue.sv
bc_execute.sv
jvm_core.sv
tb_jvm_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_jvm_core
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
